//--- sources.f
+incdir+rtl
rtl/filter_cond_pkg.sv
rtl/packet_fifo.sv
rtl/filter_cond_controller.sv
rtl/filter_cond_router.sv
rtl/filter_cond_generator.sv
test/filter_cond_assertions.sv
test/tb_filter_cond_generator.sv

//--- test/tb_filter_cond_generator.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module tb_filter_cond_generator
    import filter_cond_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    // 12 runs of up to 32 packets, 4 back-pressure runs of 40
    localparam int MAX_PKTS        = 12 * 32 + 4 * 40;
    localparam int WATCHDOG_CYCLES = MAX_PKTS * 200 + 2000;

    logic                  ap_clk;
    logic                  areset_generator;
    filter_cond_cfg_beat_t cfg_in;
    packet_beat_t          packet_in;
    logic                  out_rd_en;
    packet_beat_t          packet_out;
    logic                  in_prog_full;
    logic                  done;

    integer  seed;
    integer  rd_seed;
    int      errors;
    int      n_checked;
    int      n_expected;
    packet_t exp_q[$];
    logic    stall_mode;
    logic    hold_reads;
    logic    full_seen;

    filter_cond_generator dut0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_in           (cfg_in),
        .packet_in        (packet_in),
        .out_rd_en        (out_rd_en),
        .packet_out       (packet_out),
        .in_prog_full     (in_prog_full),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic compare_hit(filter_cond_op_e op, logic [`FC_DATA_W-1:0] data,
                                         logic [`FC_DATA_W-1:0] thr);
        case (op)
            OP_EQ:   return data == thr;
            OP_NE:   return data != thr;
            OP_LT:   return data < thr;
            default: return data >= thr;
        endcase
    endfunction

    function automatic packet_beat_t route_model(filter_cond_cfg_t c, packet_t p);
        packet_beat_t b;
        logic         hit;
        hit       = compare_hit(c.op, p.data, c.threshold);
        b.payload = p;
        if (c.conditional_flag) begin
            b.valid            = 1'b1;
            b.payload.route_to = hit ? c.route_if : c.route_else;
        end else begin
            // last always survives so that the run can end downstream
            b.valid = (hit == c.filter_pass) || p.last;
        end
        return b;
    endfunction

    // Data near the threshold so that EQ and the boundaries get hit
    function automatic logic [`FC_DATA_W-1:0] pick_data(logic [`FC_DATA_W-1:0] thr);
        case ({$random(seed)} % 4)
            0:       return thr;
            1:       return thr + 1;
            2:       return thr - 1;
            default: return $random(seed);
        endcase
    endfunction

    task automatic make_cfg(input int op, input logic fp, input logic cond,
                            output filter_cond_cfg_t c);
        c.op               = filter_cond_op_e'(op);
        c.threshold        = $random(seed);
        c.filter_pass      = fp;
        c.conditional_flag = cond;
        c.route_if         = `FC_ROUTE_W'($random(seed));
        c.route_else       = `FC_ROUTE_W'($random(seed));
    endtask

    task automatic check_value(input string name, input logic [`FC_DATA_W-1:0] got,
                               input logic [`FC_DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // ------------------------------
    // One run: configure, push, wait for done
    // ------------------------------
    task automatic run_packets(input int op, input logic fp, input logic cond,
                               input int npkts, input logic stall);
        filter_cond_cfg_t run_cfg;
        filter_cond_cfg_t stray_cfg;
        packet_t          pkt;
        packet_beat_t     exp_beat;
        int               i;
        while (!done) @(posedge ap_clk);
        make_cfg(op, fp, cond, run_cfg);
        @(posedge ap_clk);
        cfg_in     <= {1'b1, run_cfg};
        hold_reads <= stall;
        @(posedge ap_clk);
        cfg_in.valid <= 1'b0;
        @(posedge ap_clk);
        assert (done == 1'b0) else begin
            $display("done did not fall after the configuration was taken");
            errors = errors + 1;
        end
        i = 0;
        while (i < npkts) begin
            @(posedge ap_clk);
            cfg_in.valid <= 1'b0;
            if (in_prog_full) begin
                packet_in.valid <= 1'b0;
                full_seen = 1'b1;
                hold_reads <= 1'b0;
            end else if (!stall && ({$random(seed)} % 4 == 0)) begin
                packet_in.valid <= 1'b0;
            end else begin
                pkt.data     = pick_data(run_cfg.threshold);
                pkt.route_to = `FC_ROUTE_W'($random(seed));
                pkt.last     = (i == npkts - 1);
                packet_in <= {1'b1, pkt};
                exp_beat = route_model(run_cfg, pkt);
                if (exp_beat.valid) begin
                    exp_q.push_back(exp_beat.payload);
                    n_expected = n_expected + 1;
                end
                // A configuration in mid-run must not change anything
                if (i == npkts / 2) begin
                    make_cfg({$random(seed)} % 4, $random(seed), $random(seed), stray_cfg);
                    cfg_in <= {1'b1, stray_cfg};
                end
                i = i + 1;
            end
        end
        @(posedge ap_clk);
        packet_in.valid <= 1'b0;
        cfg_in.valid    <= 1'b0;
        hold_reads      <= 1'b0;
        while (!done) @(posedge ap_clk);
        while (exp_q.size() != 0) @(posedge ap_clk);
    endtask

    // ------------------------------
    // Downstream reader
    // ------------------------------
    initial begin : reader
        int   stretch;
        logic low_phase;
        stretch   = 0;
        low_phase = 1'b0;
        forever begin
            @(posedge ap_clk);
            if (stretch == 0) begin
                low_phase = ~low_phase;
                stretch   = low_phase ? 50 + {$random(rd_seed)} % 60 : 8 + {$random(rd_seed)} % 16;
            end
            stretch = stretch - 1;
            if (hold_reads || (stall_mode && low_phase)) begin
                out_rd_en <= 1'b0;
            end else if (stall_mode) begin
                out_rd_en <= $random(rd_seed);
            end else begin
                out_rd_en <= ({$random(rd_seed)} % 4) != 0;
            end
        end
    end

    // Output beats are stable at the falling edge
    always @(negedge ap_clk) begin
        packet_t exp_pkt;
        if (!areset_generator && packet_out.valid) begin
            n_checked = n_checked + 1;
            assert (exp_q.size() != 0) else begin
                $display("Unexpected packet at the output, data %h", packet_out.payload.data);
                errors = errors + 1;
            end
            if (exp_q.size() != 0) begin
                exp_pkt = exp_q.pop_front();
                check_value("packet_out.data", packet_out.payload.data, exp_pkt.data);
                check_value("packet_out.route_to", packet_out.payload.route_to, exp_pkt.route_to);
                check_value("packet_out.last", packet_out.payload.last, exp_pkt.last);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        errors = errors + 1;
        $display("Timeout after %0d cycles, the engine did not finish", WATCHDOG_CYCLES);
        $display("Packets checked %0d of %0d, errors %0d", n_checked, n_expected, errors);
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        cfg_in           = '0;
        packet_in        = '0;
        out_rd_en        = 1'b0;
        areset_generator = 1'b1;
        stall_mode       = 1'b0;
        hold_reads       = 1'b0;
        full_seen        = 1'b0;
        errors           = 0;
        n_checked        = 0;
        n_expected       = 0;
        seed             = 36673;
        rd_seed          = $random(seed);
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        check_value("done", done, 1'b1);
        check_value("packet_out.valid", packet_out.valid, 1'b0);
        check_value("in_prog_full", in_prog_full, 1'b0);
        repeat (2) @(posedge ap_clk);

        // Filter mode over all operators and both pass values
        for (int op = 0; op < 4; op++) begin
            run_packets(op, 1'b0, 1'b0, 16 + {$random(seed)} % 17, 1'b0);
            run_packets(op, 1'b1, 1'b0, 16 + {$random(seed)} % 17, 1'b0);
        end
        for (int op = 0; op < 4; op++) begin
            run_packets(op, $random(seed), 1'b1, 16 + {$random(seed)} % 17, 1'b0);
        end

        // Back-pressure with long reader stalls
        @(posedge ap_clk);
        stall_mode <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            run_packets({$random(seed)} % 4, k[0], k < 2, 40, 1'b1);
        end
        @(posedge ap_clk);
        stall_mode <= 1'b0;
        assert (full_seen) else begin
            $display("in_prog_full never rose while the reader was stalled");
            errors = errors + 1;
        end
        check_value("output packet count", n_checked, n_expected);
        errors = errors + dut0.u_assertions.fail_count;

        $display("Packets checked %0d of %0d, errors %0d", n_checked, n_expected, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/filter_cond_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_assertions
    import filter_cond_pkg::*;
(
    input logic               ap_clk,
    input logic               areset_generator,
    input logic               in_pop,
    input logic               out_prog_full,
    input logic               out_rd_en,
    input packet_beat_t       packet_out,
    input logic               done,
    input filter_cond_state_e ctrl_state
);

    logic rd_seen;
    logic run_active;
    int   fail_count;

    initial begin
        fail_count = 0;
    end

    assign run_active = (ctrl_state == ST_RUN) || (ctrl_state == ST_PAUSE) ||
                        (ctrl_state == ST_DRAIN);

    // Set by the first read request after reset
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            rd_seen <= 1'b0;
        end else if (out_rd_en) begin
            rd_seen <= 1'b1;
        end
    end

    no_pop_when_out_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_prog_full |-> !in_pop)
        else begin
            $error("input FIFO popped while the output FIFO is programmable full");
            fail_count = fail_count + 1;
        end

    done_low_in_run: assert property (@(posedge ap_clk) disable iff (areset_generator)
        run_active |-> !done)
        else begin
            $error("done is high while a run is active");
            fail_count = fail_count + 1;
        end

    no_output_before_read: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !rd_seen |-> !packet_out.valid)
        else begin
            $error("packet_out.valid rose before any read request");
            fail_count = fail_count + 1;
        end

endmodule

bind filter_cond_generator filter_cond_assertions u_assertions (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .in_pop           (in_pop),
    .out_prog_full    (out_prog_full),
    .out_rd_en        (out_rd_en),
    .packet_out       (packet_out),
    .done             (done),
    .ctrl_state       (u_controller.state)
);

`default_nettype wire

//--- rtl/filter_cond_generator.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_generator
    import filter_cond_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  filter_cond_cfg_beat_t cfg_in,
    input  packet_beat_t          packet_in,
    input  logic                  out_rd_en,
    output packet_beat_t          packet_out,
    output logic                  in_prog_full,
    output logic                  done
);

    logic             in_pop;
    logic             in_empty;
    packet_beat_t     in_beat;
    packet_beat_t     out_push;
    logic             out_prog_full;
    filter_cond_cfg_t cfg;

    // ------------------------------
    // Input side
    // ------------------------------
    packet_fifo u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (packet_in),
        .rd_en            (in_pop),
        .pop_out          (in_beat),
        .empty            (in_empty),
        .prog_full        (in_prog_full)
    );

    filter_cond_controller u_controller (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_in           (cfg_in),
        .in_empty         (in_empty),
        .out_prog_full    (out_prog_full),
        .popped           (in_beat),
        .pop              (in_pop),
        .cfg              (cfg),
        .done             (done)
    );

    // ------------------------------
    // Filter and route
    // ------------------------------
    filter_cond_router u_router (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg),
        .packet_in        (in_beat),
        .push             (out_push)
    );

    // Output side read by the downstream consumer
    packet_fifo u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (out_push),
        .rd_en            (out_rd_en),
        .pop_out          (packet_out),
        .empty            (),
        .prog_full        (out_prog_full)
    );

endmodule

`default_nettype wire

//--- rtl/filter_cond_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_router
    import filter_cond_pkg::*;
(
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  filter_cond_cfg_t cfg,
    input  packet_beat_t     packet_in,
    output packet_beat_t     push
);

    logic                   cmp_hit;
    logic                   s1_valid;
    packet_t                s1_pkt;
    logic                   s1_hit;
    logic                   keep;
    logic [`FC_ROUTE_W-1:0] route_sel;
    logic                   push_valid;
    packet_t                push_pkt;

    // ------------------------------
    // Compare kernel
    // ------------------------------
    always_comb begin
        case (cfg.op)
            OP_EQ:   cmp_hit = (packet_in.payload.data == cfg.threshold);
            OP_NE:   cmp_hit = (packet_in.payload.data != cfg.threshold);
            OP_LT:   cmp_hit = (packet_in.payload.data < cfg.threshold);
            OP_GE:   cmp_hit = (packet_in.payload.data >= cfg.threshold);
            default: cmp_hit = 1'b0;
        endcase
    end

    // ------------------------------
    // Stage 1
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= packet_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_pkt <= packet_in.payload;
        s1_hit <= cmp_hit;
    end

    // ------------------------------
    // Stage 2 rules
    // ------------------------------
    always_comb begin
        if (cfg.conditional_flag) begin
            // Conditional mode keeps all and picks a branch route
            keep      = 1'b1;
            route_sel = s1_hit ? cfg.route_if : cfg.route_else;
        end else begin
            keep      = (s1_hit == cfg.filter_pass) | s1_pkt.last;
            route_sel = s1_pkt.route_to;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= s1_valid & keep;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_pkt.data     <= s1_pkt.data;
        push_pkt.route_to <= route_sel;
        push_pkt.last     <= s1_pkt.last;
    end

    assign push = {push_valid, push_pkt};

endmodule

`default_nettype wire

//--- rtl/filter_cond_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module filter_cond_controller
    import filter_cond_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  filter_cond_cfg_beat_t cfg_in,
    input  logic                  in_empty,
    input  logic                  out_prog_full,
    input  packet_beat_t          popped,
    output logic                  pop,
    output filter_cond_cfg_t      cfg,
    output logic                  done
);

    // Pop to push latency of the FIFO read plus both router stages
    localparam int DRAIN_CYCLES = 3;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

    filter_cond_state_e state;
    filter_cond_state_e next_state;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               last_seen;
    logic               cfg_take;
    logic               drain_end;

    assign last_seen = popped.valid & popped.payload.last;
    assign cfg_take  = (state == ST_IDLE) & cfg_in.valid;
    assign drain_end = (state == ST_DRAIN) & (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1));

    // Last packet at the FIFO output blocks the pop in the same cycle
    assign pop = (state == ST_RUN) & ~in_empty & ~out_prog_full & ~last_seen;

    // ------------------------------
    // Run FSM
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET: begin
                next_state = ST_IDLE;
            end
            ST_IDLE: begin
                if (cfg_in.valid) begin
                    next_state = ST_RUN;
                end
            end
            ST_RUN: begin
                if (last_seen) begin
                    next_state = ST_DRAIN;
                end else if (out_prog_full) begin
                    next_state = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (~out_prog_full) begin
                    next_state = ST_RUN;
                end
            end
            ST_DRAIN: begin
                if (drain_end) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Counts cycles spent in drain
    always_ff @(posedge ap_clk) begin
        if (areset_generator || state != ST_DRAIN) begin
            drain_cnt <= '0;
        end else begin
            drain_cnt <= drain_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Configuration and done
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg  <= '0;
            done <= 1'b1;
        end else if (cfg_take) begin
            cfg  <= cfg_in.payload;
            done <= 1'b0;
        end else if (drain_end) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/packet_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_cond_params.svh"

module packet_fifo
    import filter_cond_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  packet_beat_t push,
    input  logic         rd_en,
    output packet_beat_t pop_out,
    output logic         empty,
    output logic         prog_full
);

    localparam int ADDR_W  = $clog2(`FC_FIFO_DEPTH);
    localparam int COUNT_W = $clog2(`FC_FIFO_DEPTH + 1);

    packet_t            mem [`FC_FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               full;
    logic               wr_fire;
    logic               rd_fire;
    logic               rd_valid;
    packet_t            rd_data;

    // ------------------------------
    // Occupancy flags
    // ------------------------------
    assign full      = (count == COUNT_W'(`FC_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= COUNT_W'(`FC_PROG_THRESH));

    // Push into a full FIFO and pop from an empty one are both dropped
    assign wr_fire = push.valid & ~full;
    assign rd_fire = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= push.payload;
        end
    end

    // ------------------------------
    // Pointers and count
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Read data shows one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_fire) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assign pop_out = {rd_valid, rd_data};

endmodule

`default_nettype wire

//--- rtl/filter_cond_pkg.sv
`default_nettype none

`include "filter_cond_params.svh"

package filter_cond_pkg;

    // ------------------------------
    // Enumerations
    // ------------------------------

    // Unsigned compare of data against threshold
    typedef enum logic [1:0] {
        OP_EQ,
        OP_NE,
        OP_LT,
        OP_GE
    } filter_cond_op_e;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_RUN,
        ST_PAUSE,
        ST_DRAIN
    } filter_cond_state_e;

    // ------------------------------
    // Packets
    // ------------------------------

    typedef struct packed {
        logic [`FC_DATA_W-1:0]  data;
        logic [`FC_ROUTE_W-1:0] route_to;
        logic                   last;
    } packet_t;

    typedef struct packed {
        logic    valid;
        packet_t payload;
    } packet_beat_t;

    // ------------------------------
    // Configuration
    // ------------------------------

    typedef struct packed {
        filter_cond_op_e        op;
        logic [`FC_DATA_W-1:0]  threshold;
        logic                   filter_pass;
        logic                   conditional_flag;
        logic [`FC_ROUTE_W-1:0] route_if;
        logic [`FC_ROUTE_W-1:0] route_else;
    } filter_cond_cfg_t;

    typedef struct packed {
        logic             valid;
        filter_cond_cfg_t payload;
    } filter_cond_cfg_beat_t;

endpackage

`default_nettype wire

//--- rtl/filter_cond_params.svh
`ifndef FILTER_COND_PARAMS_SVH
`define FILTER_COND_PARAMS_SVH

// ------------------------------
// Packet fields
// ------------------------------

// Payload word compared against the threshold
`define FC_DATA_W 32

// Destination id carried with each packet
`define FC_ROUTE_W 4

// ------------------------------
// FIFO sizing
// ------------------------------

// Entries per packet FIFO, power of two
`define FC_FIFO_DEPTH 16

// Fill level for prog_full
// Keeps room for the three packets in flight in the pipeline
`define FC_PROG_THRESH 12

`endif
